//--- Bender.yml
package:
  name: phs_avg

sources:
  # Packages first, then RTL bottom up
  - src/phs_dsp_pkg.sv
  - src/phs_host_pkg.sv
  - src/prl_gain_bank.sv
  - src/phs_avg_mul.sv
  - src/phs_avg.sv
  - src/phs_avg_top.sv
  # Testbench and bound assertions
  - target: test
    files:
      - bench/phs_avg_asserts.sv
      - bench/phs_avg_tb.sv

//--- bench/phs_avg_asserts.sv
`timescale 1ns/1ns

// Protocol and reset checks on the phase averaging top level
module phs_avg_asserts #(
	parameter int dwi = 17
) (
	input  logic clk,
	input  logic rst,
	input  phs_dsp_pkg::stream_sample_t sample,
	input  logic gain_pending,
	input  logic signed [dwi+1:0] z
);

	// Failed assertions so far, read at the end of the run
	int fail_count = 0;

	// Reset drops any pending commit
	pending_low_after_reset: assert property (@(posedge clk) rst |=> !gain_pending)
		else begin
			fail_count++;
			$error("gain_pending is high after a reset edge");
		end

	// Real and imaginary parts strictly alternate
	iq_alternates: assert property (@(posedge clk) disable iff (rst)
		sample.iq != $past(sample.iq))
		else begin
			fail_count++;
			$error("iq did not toggle between cycles");
		end

	// Empty pipeline, so z stays zero two edges into the run
	z_zero_after_reset: assert property (@(posedge clk)
		($fell(rst) && sample.fwd == '0 && sample.rev == '0) |-> ##2 (z == '0))
		else begin
			fail_count++;
			$error("z is not zero two cycles after reset");
		end

endmodule

bind phs_avg_top phs_avg_asserts #(
	.dwi(dwi)
) asserts_i (
	.clk(clk),
	.rst(rst),
	.sample(sample),
	.gain_pending(gain_pending),
	.z(z)
);

//--- bench/phs_avg_tb.sv
`timescale 1ns/1ns

module phs_avg_tb;

	localparam int dwi = phs_dsp_pkg::dwi;
	localparam int dwj = phs_dsp_pkg::dwj;
	localparam int clk_period = 20;
	localparam int reset_cycles = 4;
	localparam int idle_cycles = 4;
	localparam int margin_cycles = 50;

	// One table row: gains, fixed sample pair, control flags and run length
	typedef struct packed {
		logic signed [dwj-1:0] kx_re;
		logic signed [dwj-1:0] kx_im;
		logic signed [dwj-1:0] ky_re;
		logic signed [dwj-1:0] ky_im;
		logic signed [dwi-1:0] fwd_re;
		logic signed [dwi-1:0] fwd_im;
		logic signed [dwi-1:0] rev_re;
		logic signed [dwi-1:0] rev_im;
		logic commit;
		logic clear;
		logic rnd;
		logic [15:0] run_len;
	} row_t;

	logic clk;
	logic rst;
	phs_dsp_pkg::stream_sample_t sample;
	phs_host_pkg::host_wr_t host_wr;
	logic commit;
	logic intg_clear;
	logic signed [dwi+1:0] z;
	logic gain_pending;

	row_t rows [$];
	logic table_ready;
	// Phase of the next driven sample
	logic iq_phase;
	logic [31:0] lfsr_state;
	int err_count;
	int cycle_count;

	// Reference state, updated once per clock edge
	longint m_shadow [4];
	longint m_active [4];
	logic m_pending;
	longint m_y1 [2];
	longint m_prod [2];
	longint m_sum;
	longint m_intg;

	phs_avg_top #(
		.dwi(dwi),
		.dwj(dwj)
	) dut_i (
		.clk(clk),
		.rst(rst),
		.sample(sample),
		.host_wr(host_wr),
		.commit(commit),
		.intg_clear(intg_clear),
		.z(z),
		.gain_pending(gain_pending)
	);

	initial clk = 1'b0;
	always #(clk_period / 2) clk = ~clk;

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// Keep the low w bits of v as a two's complement number
	function automatic longint wrap_signed(input longint v, input int w);
		longint m;
		longint r;
		m = longint'(1) << w;
		r = v & (m - 1);
		if (r >= (m >> 1)) begin
			r = r - m;
		end
		return r;
	endfunction

	// Product bits dwj+dwi-2 down to dwi-4
	function automatic longint product_window(input longint p);
		return wrap_signed(p >>> (dwi - 4), dwj + dwi - 2 - (dwi - 4) + 1);
	endfunction

	task automatic model_reset();
		for (int i = 0; i < 4; i++) begin
			m_shadow[i] = 0;
			m_active[i] = 0;
		end
		for (int s = 0; s < 2; s++) begin
			m_y1[s] = 0;
			m_prod[s] = 0;
		end
		m_pending = 1'b0;
		m_sum = 0;
		m_intg = 0;
	endtask

	// State after the coming edge, from the inputs of this cycle
	task automatic model_step(input logic iq, input longint fwd, input longint rev,
			input phs_host_pkg::host_wr_t wr, input logic cmt, input logic clr);
		longint x [2];
		longint g [2];
		longint n_prod [2];
		longint n_sum;
		logic xfer;
		x[0] = fwd;
		x[1] = rev;
		// Gain read at the address given by this cycle's iq
		g[0] = iq ? m_active[phs_host_pkg::KX_RE] : m_active[phs_host_pkg::KX_IM];
		g[1] = iq ? m_active[phs_host_pkg::KY_RE] : m_active[phs_host_pkg::KY_IM];
		for (int s = 0; s < 2; s++) begin
			// Sample times the gain read one cycle earlier
			n_prod[s] = x[s] * m_y1[s];
			m_y1[s] = g[s];
		end
		n_sum = wrap_signed(product_window(m_prod[0]) + product_window(m_prod[1]), dwi + 3);
		// Integrator wraps, clear wins over accumulation
		m_intg = clr ? 0 : wrap_signed(m_intg + m_sum, dwi + 4);
		m_sum = n_sum;
		m_prod[0] = n_prod[0];
		m_prod[1] = n_prod[1];
		// Shadow set moves on the first real sample after a commit
		xfer = m_pending && iq;
		if (xfer) begin
			for (int i = 0; i < 4; i++) begin
				m_active[i] = m_shadow[i];
			end
		end
		m_pending = xfer ? 1'b0 : (cmt ? 1'b1 : m_pending);
		if (wr.wr) begin
			m_shadow[wr.addr] = longint'($signed(wr.data));
		end
	endtask

	task automatic check_outputs();
		logic [dwi+1:0] exp_z;
		exp_z = m_intg[dwi+2:1];
		if (z !== exp_z) begin
			$display("Mismatch z at cycle %0d: got %h expected %h", cycle_count, z, exp_z);
			err_count++;
		end
		if (gain_pending !== m_pending) begin
			$display("Mismatch gain_pending at cycle %0d: got %h expected %h",
				cycle_count, gain_pending, m_pending);
			err_count++;
		end
	endtask

	// Drive one cycle at the falling edge and check after the next rising edge
	task automatic run_cycle(input logic signed [dwi-1:0] fwd, input logic signed [dwi-1:0] rev,
			input phs_host_pkg::host_wr_t wr, input logic cmt, input logic clr);
		sample.iq = iq_phase;
		sample.fwd = fwd;
		sample.rev = rev;
		host_wr = wr;
		commit = cmt;
		intg_clear = clr;
		model_step(iq_phase, longint'(fwd), longint'(rev), wr, cmt, clr);
		iq_phase = !iq_phase;
		@(posedge clk);
		@(negedge clk);
		cycle_count++;
		check_outputs();
	endtask

	task automatic pick_sample(input row_t r, output logic signed [dwi-1:0] fwd,
			output logic signed [dwi-1:0] rev);
		logic [31:0] bits;
		if (r.rnd) begin
			draw_bits(dwi, bits);
			fwd = bits[dwi-1:0];
			draw_bits(dwi, bits);
			rev = bits[dwi-1:0];
		end else begin
			fwd = iq_phase ? r.fwd_re : r.fwd_im;
			rev = iq_phase ? r.rev_re : r.rev_im;
		end
	endtask

	// Four shadow writes, optional commit, then the run with an optional clear
	task automatic apply_row(input row_t r);
		logic signed [dwj-1:0] gains [4];
		logic [31:0] bits;
		phs_host_pkg::host_wr_t wr;
		logic signed [dwi-1:0] fwd;
		logic signed [dwi-1:0] rev;
		if (r.rnd) begin
			for (int k = 0; k < 4; k++) begin
				draw_bits(dwj, bits);
				gains[k] = bits[dwj-1:0];
			end
		end else begin
			gains[phs_host_pkg::KX_RE] = r.kx_re;
			gains[phs_host_pkg::KX_IM] = r.kx_im;
			gains[phs_host_pkg::KY_RE] = r.ky_re;
			gains[phs_host_pkg::KY_IM] = r.ky_im;
		end
		for (int k = 0; k < 4; k++) begin
			wr.wr = 1'b1;
			wr.addr = phs_host_pkg::gain_sel_t'(k);
			wr.data = gains[k];
			pick_sample(r, fwd, rev);
			run_cycle(fwd, rev, wr, 1'b0, 1'b0);
		end
		wr = '0;
		if (r.commit) begin
			pick_sample(r, fwd, rev);
			run_cycle(fwd, rev, wr, 1'b1, 1'b0);
		end
		for (int i = 0; i < r.run_len; i++) begin
			pick_sample(r, fwd, rev);
			// Clear lands mid-run so the restart from the held sum is visible
			run_cycle(fwd, rev, wr, 1'b0, r.clear && (i == r.run_len / 2));
		end
	endtask

	task automatic add_row(input int kx_re, input int kx_im, input int ky_re, input int ky_im,
			input int fwd_re, input int fwd_im, input int rev_re, input int rev_im,
			input logic cmt, input logic clr, input logic rnd, input int run_len);
		row_t r;
		r.kx_re = kx_re;
		r.kx_im = kx_im;
		r.ky_re = ky_re;
		r.ky_im = ky_im;
		r.fwd_re = fwd_re;
		r.fwd_im = fwd_im;
		r.rev_re = rev_re;
		r.rev_im = rev_im;
		r.commit = cmt;
		r.clear = clr;
		r.rnd = rnd;
		r.run_len = run_len;
		rows.push_back(r);
	endtask

	task automatic load_table();
		// Forward stream alone, then reverse stream alone
		add_row(4096, 2048, 0, 0, 16384, -8192, 0, 0, 1'b1, 1'b0, 1'b0, 24);
		add_row(0, 0, 3072, -1024, 0, 0, -12000, 9000, 1'b1, 1'b0, 1'b0, 24);
		// Both streams at once
		add_row(-5000, 7000, 2500, 11000, 30000, -20000, -15000, 25000, 1'b1, 1'b0, 1'b0, 24);
		// New gains in shadow only, slope must stay
		add_row(1234, -4321, 8000, -8000, 30000, -20000, -15000, 25000, 1'b0, 1'b0, 1'b0, 16);
		// Same gains committed
		add_row(1234, -4321, 8000, -8000, 30000, -20000, -15000, 25000, 1'b1, 1'b0, 1'b0, 16);
		// Integrator clear
		add_row(1234, -4321, 8000, -8000, 30000, -20000, -15000, 25000, 1'b0, 1'b1, 1'b0, 16);
		// Full scale corners, product window and integrator wrap
		add_row(-32768, -32768, 32767, -32768, -65536, -65536, 65535, -65536,
			1'b1, 1'b0, 1'b0, 40);
		// Random samples and gains
		add_row(0, 0, 0, 0, 0, 0, 0, 0, 1'b1, 1'b0, 1'b1, 200);
		add_row(0, 0, 0, 0, 0, 0, 0, 0, 1'b1, 1'b1, 1'b1, 300);
		add_row(0, 0, 0, 0, 0, 0, 0, 0, 1'b0, 1'b0, 1'b1, 100);
		add_row(0, 0, 0, 0, 0, 0, 0, 0, 1'b1, 1'b0, 1'b1, 150);
	endtask

	// Watchdog sized from the table
	initial begin
		longint limit_cycles;
		wait (table_ready === 1'b1);
		limit_cycles = reset_cycles + idle_cycles + margin_cycles;
		foreach (rows[i]) begin
			limit_cycles += 4 + rows[i].commit + rows[i].run_len;
		end
		#(limit_cycles * clk_period);
		$display("Watchdog expired after %0d cycles, the run did not finish", limit_cycles);
		$display("Test failures found");
		$finish;
	end

	initial begin
		int assert_fails;
		rst = 1'b1;
		sample = '0;
		host_wr = '0;
		commit = 1'b0;
		intg_clear = 1'b0;
		err_count = 0;
		cycle_count = 0;
		lfsr_state = 32'hb73c;
		table_ready = 1'b0;
		iq_phase = 1'b1;
		load_table();
		table_ready = 1'b1;
		// First reset edge sees iq low, the next three keep it alternating
		repeat (reset_cycles - 1) begin
			@(posedge clk);
			@(negedge clk);
			sample.iq = iq_phase;
			iq_phase = !iq_phase;
		end
		@(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		model_reset();
		// Right after reset z is zero and no commit is pending
		check_outputs();
		repeat (idle_cycles) begin
			run_cycle('0, '0, '0, 1'b0, 1'b0);
		end
		foreach (rows[i]) begin
			apply_row(rows[i]);
		end
		assert_fails = dut_i.asserts_i.fail_count;
		$display("Summary: %0d cycles, %0d mismatches, %0d assertion failures",
			cycle_count, err_count, assert_fails);
		if (err_count == 0 && assert_fails == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- sim.f
src/phs_dsp_pkg.sv
src/phs_host_pkg.sv
src/prl_gain_bank.sv
src/phs_avg_mul.sv
src/phs_avg.sv
src/phs_avg_top.sv
bench/phs_avg_asserts.sv
bench/phs_avg_tb.sv

//--- src/phs_avg.sv
`timescale 1ns/1ns

// Phase averager
// Imaginary cross terms of fwd*kx and rev*ky, summed and integrated
module phs_avg #(
	parameter int dwi = 17,
	parameter int dwj = 16
) (
	input  logic clk,
	input  logic rst,
	// Zeros the integrator on this edge
	input  logic intg_clear,
	// Interleaved forward and reverse samples
	input  phs_dsp_pkg::stream_sample_t sample,
	// Gain components returned for kx_addr and ky_addr
	input  logic signed [dwj-1:0] kx,
	input  logic signed [dwj-1:0] ky,
	// Gain read addresses, 1 selects the real part
	output logic [0:0] kx_addr,
	output logic [0:0] ky_addr,
	// Integrated phase error
	output logic signed [dwi+1:0] z
);

	// Aligned cross-term products
	logic signed [dwi+1:0] xmr;
	logic signed [dwi+1:0] ymr;
	// One extra bit for the sum of two products
	logic signed [dwi+2:0] sum;
	// Integrator, one more bit, wraps on overflow
	logic signed [dwi+3:0] intg;

	// The gain is read on the same phase as the sample
	// The multiplier delay turns this into the opposite part
	assign kx_addr = sample.iq;
	assign ky_addr = sample.iq;

	// Forward stream times kx
	phs_avg_mul #(
		.dwi(dwi),
		.dwj(dwj)
	) xmul (
		.clk(clk),
		.rst(rst),
		.iq(sample.iq),
		.x(sample.fwd),
		.y(kx),
		.z(xmr)
	);

	// Reverse stream times ky
	phs_avg_mul #(
		.dwi(dwi),
		.dwj(dwj)
	) ymul (
		.clk(clk),
		.rst(rst),
		.iq(sample.iq),
		.x(sample.rev),
		.y(ky),
		.z(ymr)
	);

	// Sum one edge after the products
	always_ff @(posedge clk) begin
		if (rst) begin
			sum <= '0;
		end else begin
			sum <= xmr + ymr;
		end
	end

	// Integrator
	// A clear zeros it but leaves sum in place
	// The edge after a clear loads the pending sum
	always_ff @(posedge clk) begin
		if (rst) begin
			intg <= '0;
		end else if (intg_clear) begin
			intg <= '0;
		end else begin
			intg <= intg + sum;
		end
	end

	// Drop the lsb and the top guard bit
	assign z = intg[dwi+2:1];

endmodule

//--- src/phs_avg_mul.sv
`timescale 1ns/1ns

// Interleaved real-by-imaginary multiplier, imaginary part of x*y only
module phs_avg_mul #(
	parameter int dwi = 17,
	parameter int dwj = 16
) (
	input  logic clk,
	input  logic rst,
	// High when x and y carry the real part
	input  logic iq,
	input  logic signed [dwi-1:0] x,
	input  logic signed [dwj-1:0] y,
	output logic signed [dwi+1:0] z
);

	// Gain delayed by one cycle, one copy per phase
	logic signed [dwj-1:0] y1_re;
	logic signed [dwj-1:0] y1_im;
	// Full precision product
	logic signed [dwi+dwj-1:0] prod;

	always_ff @(posedge clk) begin
		if (rst) begin
			y1_re <= '0;
			y1_im <= '0;
			prod <= '0;
		end else begin
			// Gain part follows the phase it was read on
			if (iq) begin
				y1_re <= y;
			end else begin
				y1_im <= y;
			end
			// Real sample meets the imaginary gain of the previous cycle
			// Imaginary sample meets the real gain
			prod <= x * (iq ? y1_im : y1_re);
		end
	end

	// Drop the duplicated sign bit and the low bits
	assign z = prod[dwj+dwi-2:dwi-4];

endmodule

//--- src/phs_avg_top.sv
`timescale 1ns/1ns

// Phase averaging top level
// Gain bank feeding the phase averager, no logic of its own
module phs_avg_top #(
	parameter int dwi = phs_dsp_pkg::dwi,
	parameter int dwj = phs_dsp_pkg::dwj
) (
	input  logic clk,
	input  logic rst,
	// Interleaved forward and reverse stream, one sample per cycle
	input  phs_dsp_pkg::stream_sample_t sample,
	// Host gain register writes
	input  phs_host_pkg::host_wr_t host_wr,
	// Apply the shadow gains at the next real sample
	input  logic commit,
	// Restart the integration
	input  logic intg_clear,
	// Integrated phase error, two edges behind the sample
	output logic signed [dwi+1:0] z,
	// Commit not yet applied
	output logic gain_pending
);

	// Gain read addresses from the averager
	logic [0:0] kx_addr;
	logic [0:0] ky_addr;
	// Active gains at those addresses
	logic signed [dwj-1:0] kx;
	logic signed [dwj-1:0] ky;

	// Gain registers
	// The averager reads them like an external memory
	prl_gain_bank #(
		.dwj(dwj)
	) gain_bank (
		.clk(clk),
		.rst(rst),
		.host_wr(host_wr),
		.commit(commit),
		.iq(sample.iq),
		.kx_addr(kx_addr),
		.ky_addr(ky_addr),
		.kx(kx),
		.ky(ky),
		.gain_pending(gain_pending)
	);

	// Multipliers, cross-term adder and integrator
	phs_avg #(
		.dwi(dwi),
		.dwj(dwj)
	) avg (
		.clk(clk),
		.rst(rst),
		.intg_clear(intg_clear),
		.sample(sample),
		.kx(kx),
		.ky(ky),
		.kx_addr(kx_addr),
		.ky_addr(ky_addr),
		.z(z)
	);

	// Latency is that of the averager
	// Sample at edge n shows on z after edge n+2
	// Gain committed on a real sample reaches the next full pair

endmodule

//--- src/phs_dsp_pkg.sv
// Datapath definitions shared by the phase averager and its stream source
package phs_dsp_pkg;

	// Width of one forward or reverse I/Q sample
	// Default for the dwi parameter passed down from the top level
	localparam int dwi = 17;

	// Width of one component of a complex gain
	// Default for the dwj parameter passed down from the top level
	localparam int dwj = 16;

	// One cycle of the interleaved stream
	// Both streams share the iq flag
	// iq high marks the real part, iq low the imaginary part
	// Real and imaginary parts alternate every cycle
	//
	// Layout, msb first:
	//   iq  : 1 bit
	//   fwd : dwi bits, forward downconverted sample
	//   rev : dwi bits, reverse downconverted sample
	typedef struct packed {
		// Real/imaginary flag for both samples below
		logic iq;
		// Forward stream sample, two's complement
		logic signed [dwi-1:0] fwd;
		// Reverse stream sample, two's complement
		logic signed [dwi-1:0] rev;
	} stream_sample_t;

	// Each stream is multiplied by its own complex gain
	//   fwd * kx  and  rev * ky
	// Only the imaginary part of each product is kept
	//   Im{(a + ib)(c + id)} = a*d + b*c
	// With interleaved data this is one real-by-imaginary product per cycle
	// The two imaginary cross terms are summed and integrated
	// The integrator is not saturated and wraps on overflow
	//
	// The averager output is dwi+2 bits wide
	// It is the integrator with its lsb dropped
	//
	// Latency from a sample to the output is two edges
	// One edge for the product, one for the sum, then the integrator

endpackage

//--- src/phs_host_pkg.sv
// Host side definitions for the gain register bank
package phs_host_pkg;

	// Width of a host data word
	localparam int hdw = 16;

	// Gain register address
	// Bit 0 set selects a real part, matching the iq flag of the stream
	// Bit 1 selects the reverse stream gain
	typedef enum logic [1:0] {
		KX_IM = 2'd0,
		KX_RE = 2'd1,
		KY_IM = 2'd2,
		KY_RE = 2'd3
	} gain_sel_t;

	// One host write cycle
	// A write lands in the shadow register on the edge where wr is high
	// Shadow values reach the datapath only after a commit
	//
	// Layout, msb first:
	//   wr   : 1 bit, write strobe
	//   addr : 2 bits, gain register
	//   data : hdw bits, two's complement gain component
	typedef struct packed {
		// Write strobe, one cycle per register
		logic wr;
		// Which gain component to write
		gain_sel_t addr;
		// New gain component value
		logic [hdw-1:0] data;
	} host_wr_t;

endpackage

//--- src/prl_gain_bank.sv
`timescale 1ns/1ns

// PRL gain bank with shadow and active copies of kx and ky
module prl_gain_bank #(
	parameter int dwj = 16
) (
	input  logic clk,
	input  logic rst,
	// Host register writes into the shadow set
	input  phs_host_pkg::host_wr_t host_wr,
	// One-cycle request to move the shadow set into the active set
	input  logic commit,
	// Stream phase, high on a real sample
	input  logic iq,
	// Read addresses from the averager, 1 selects the real part
	input  logic [0:0] kx_addr,
	input  logic [0:0] ky_addr,
	// Active gains at the requested addresses
	output logic signed [dwj-1:0] kx,
	output logic signed [dwj-1:0] ky,
	// Commit requested but not yet applied
	output logic gain_pending
);

	// Host facing copy, written one component at a time
	logic signed [dwj-1:0] shadow_q [0:3];
	// Copy seen by the multipliers
	logic signed [dwj-1:0] active_q [0:3];
	// Commit waiting for the next real sample
	logic pending_q;
	// Transfer happens on a real sample so a pair never mixes old and new
	logic xfer;

	assign xfer = pending_q && iq;

	// Shadow registers
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 4; i++) begin
				shadow_q[i] <= '0;
			end
		end else if (host_wr.wr) begin
			// Only the addressed component changes
			shadow_q[host_wr.addr] <= host_wr.data;
		end
	end

	// Active registers
	// All four components move together
	// The transfer takes the shadow values from before any write on this edge
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 4; i++) begin
				active_q[i] <= '0;
			end
		end else if (xfer) begin
			for (int i = 0; i < 4; i++) begin
				active_q[i] <= shadow_q[i];
			end
		end
	end

	// Pending flag
	// Set by a commit, cleared by the transfer
	// A commit while already pending is absorbed
	always_ff @(posedge clk) begin
		if (rst) begin
			pending_q <= 1'b0;
		end else if (xfer) begin
			pending_q <= 1'b0;
		end else if (commit) begin
			pending_q <= 1'b1;
		end
	end

	assign gain_pending = pending_q;

	// Address-indexed reads from the active set
	// Looks like the external gain memory of the averager
	always_comb begin
		if (kx_addr[0]) begin
			kx = active_q[phs_host_pkg::KX_RE];
		end else begin
			kx = active_q[phs_host_pkg::KX_IM];
		end
	end

	always_comb begin
		if (ky_addr[0]) begin
			ky = active_q[phs_host_pkg::KY_RE];
		end else begin
			ky = active_q[phs_host_pkg::KY_IM];
		end
	end

	// Reads are combinational
	// The multiplier registers the gain once more before use
	// A component written and committed reaches a product three edges later at most

endmodule
